// ==== filelist.f ====
source/z80_dp_pkg.sv
source/pipe_reg.sv
source/regfile.sv
source/alu8.sv
source/alu16.sv
source/writeback.sv
source/datapath_top.sv
sim/datapath_sva.sv
sim/tb_datapath.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_datapath \
  -f filelist.f -o tb_datapath > build.log 2>&1 &&
./obj_dir/tb_datapath > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
grep -q "Finished with no errors" sim.log && echo "PASS" || { cat sim.log; echo "FAIL"; exit 1; }

// ==== sim/datapath_sva.sv ====
`timescale 1ns/1ps

module datapath_sva import z80_dp_pkg::*; (
  input logic    clk,
  input logic    rst,
  input logic    cmd_valid,
  input logic    cmd_ready,
  input dp_cmd_t cmd,
  input logic    res_valid,
  input logic    res_ready,
  input dp_res_t res
);

  // ----------------------------------------
  // valid/ready hold rules
  // ----------------------------------------

  // a stalled command is offered again unchanged on the next edge
  a_cmd_held: assert property (@(posedge clk) disable iff (rst)
    (cmd_valid && !cmd_ready) |=> (cmd_valid && $stable(cmd)))
    else $error("cmd dropped or changed while stalled");

  // the output slot keeps its result until the sink takes it
  a_res_held: assert property (@(posedge clk) disable iff (rst)
    (res_valid && !res_ready) |=> (res_valid && $stable(res)))
    else $error("res dropped or changed while stalled");

  // nothing comes out of an output slot that reset has just cleared
  a_res_idle_in_reset: assert property (@(posedge clk) rst |=> !res_valid)
    else $error("res_valid high during reset");

endmodule

bind datapath_top datapath_sva i_sva (
  .clk(clk), .rst(rst),
  .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd(cmd),
  .res_valid(res_valid), .res_ready(res_ready), .res(res)
);

// ==== sim/tb_datapath.sv ====
`timescale 1ns/1ps

module tb_datapath import z80_dp_pkg::*; ();

  localparam int num_cmds  = 400;
  localparam int cycle_lim = num_cmds * 8 + 200;
  // the first results drain with no stalls at all, so their latency is fixed
  localparam int free_cmds = 20;

  logic    clk;
  logic    rst;
  logic    cmd_valid;
  logic    cmd_ready;
  dp_cmd_t cmd;
  logic    res_valid;
  logic    res_ready;
  dp_res_t res;

  // reference copy of the architectural state
  logic [byte_w-1:0] m_acc;
  logic [byte_w-1:0] m_f;
  logic [byte_w-1:0] m_acc_sh;
  logic [byte_w-1:0] m_f_sh;
  logic [byte_w-1:0] m_bank   [num_regs];
  logic [byte_w-1:0] m_shadow [num_regs];

  dp_res_t     exp_q [$];
  int          cyc_q [$];
  logic [31:0] rng;
  int          cycles = 0;
  int          err_count = 0;
  int          sent;
  int          got;

  always #20 clk = ~clk;

  datapath_top i_dut (
    .clk(clk), .rst(rst),
    .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd(cmd),
    .res_valid(res_valid), .res_ready(res_ready), .res(res)
  );

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got_v,
                          input logic [31:0] exp_v);
    if (got_v !== exp_v) begin
      err_count++;
      abort_run($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got_v, exp_v));
    end
  endtask

  function automatic dp_cmd_t random_cmd();
    logic [31:0] r1;
    logic [31:0] r2;
    dp_cmd_t     c;
    r1 = next_rand();
    r2 = next_rand();
    c.op   = op_e'(4'(r1 % 32'd13));
    c.dst  = reg8_e'(r2[2:0]);
    c.src  = reg8_e'(r2[6:4]);
    // only BC, DE and HL exist
    c.pair = pair_e'(2'(r2[23:8] % 16'd3));
    c.imm  = r2[31:24];
    return c;
  endfunction

  // flags of a byte add or subtract, straight from the arithmetic
  function automatic logic [7:0] arith_flags(input logic sub, input logic [7:0] a,
                                             input logic [7:0] b, output logic [7:0] r);
    int         full;
    int         half;
    int         sgn;
    logic [7:0] fl;
    fl   = '0;
    full = sub ? int'(a) - int'(b) : int'(a) + int'(b);
    half = sub ? int'(a[3:0]) - int'(b[3:0]) : int'(a[3:0]) + int'(b[3:0]);
    sgn  = sub ? int'($signed(a)) - int'($signed(b)) : int'($signed(a)) + int'($signed(b));
    r = full[7:0];
    fl[flag_s]  = r[7];
    fl[flag_z]  = (r == 8'h00);
    fl[flag_h]  = sub ? (half < 0) : (half > 15);
    // signed result that no longer fits in a byte
    fl[flag_pv] = (sgn > 127) || (sgn < -128);
    fl[flag_n]  = sub;
    fl[flag_c]  = sub ? (full < 0) : (full > 255);
    return fl;
  endfunction

  // applies one accepted command to the model and gives the result it expects
  task automatic apply_model(input dp_cmd_t c, output dp_res_t e);
    logic [7:0]  opnd;
    logic [7:0]  r;
    logic [7:0]  tmp;
    logic [2:0]  hi;
    logic [15:0] pv;
    logic [15:0] nv;
    logic [7:0]  keep [num_regs];
    hi = {c.pair, 1'b0};
    pv = {m_bank[hi], m_bank[hi + 3'd1]};
    case (c.src)
      reg_a:   opnd = m_acc;
      reg_imm: opnd = c.imm;
      default: opnd = m_bank[c.src];
    endcase
    // non-word commands report the pair as it was read before the edge
    e.pair_val = pv;
    case (c.op)
      op_ld: begin
        if (c.dst == reg_a) begin
          m_acc = opnd;
        end else if (c.dst != reg_imm) begin
          m_bank[c.dst] = opnd;
        end
      end
      op_add, op_sub: begin
        m_f   = arith_flags(c.op == op_sub, m_acc, opnd, r);
        m_acc = r;
      end
      op_inc_a, op_dec_a: begin
        tmp = arith_flags(c.op == op_dec_a, m_acc, 8'h01, r);
        tmp[flag_c] = m_f[flag_c];
        m_f   = tmp;
        m_acc = r;
      end
      op_scf: begin
        m_f[flag_c] = 1'b1;
        m_f[flag_h] = 1'b0;
        m_f[flag_n] = 1'b0;
      end
      op_ccf: begin
        m_f[flag_h] = m_f[flag_c];
        m_f[flag_c] = !m_f[flag_c];
        m_f[flag_n] = 1'b0;
      end
      op_inc16, op_dec16, op_add_se: begin
        if (c.op == op_inc16) nv = pv + 16'd1;
        else if (c.op == op_dec16) nv = pv - 16'd1;
        else nv = pv + {{8{c.imm[7]}}, c.imm};
        m_bank[hi]        = nv[15:8];
        m_bank[hi + 3'd1] = nv[7:0];
        e.pair_val        = nv;
      end
      op_ex_af: begin
        tmp      = m_acc;
        m_acc    = m_acc_sh;
        m_acc_sh = tmp;
        tmp      = m_f;
        m_f      = m_f_sh;
        m_f_sh   = tmp;
      end
      op_exx: begin
        keep     = m_bank;
        m_bank   = m_shadow;
        m_shadow = keep;
      end
      default: begin
      end
    endcase
    e.acc   = m_acc;
    e.flags = m_f;
  endtask

  // ----------------------------------------
  // stimulus and scoreboard
  // ----------------------------------------
  initial begin
    dp_res_t e;
    int      t0;
    logic    stall;
    logic    cmd_took;
    logic    res_took;
    clk = 1'b0;
    rst = 1'b1;
    cmd_valid = 1'b0;
    res_ready = 1'b0;
    cmd = '0;
    rng = 32'd91917;
    m_acc = '0;
    m_f = '0;
    m_acc_sh = '0;
    m_f_sh = '0;
    for (int i = 0; i < num_regs; i++) begin
      m_bank[i]   = '0;
      m_shadow[i] = '0;
    end
    sent = 0;
    got = 0;
    cmd_took = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (got < num_cmds) begin
      stall = (got >= free_cmds);
      // a command once offered stays put until it is taken
      if (!cmd_valid || cmd_took) begin
        cmd_valid = 1'b0;
        if (sent < num_cmds && (!stall || next_rand() % 32'd4 != 32'd0)) begin
          cmd       = random_cmd();
          cmd_valid = 1'b1;
        end
      end
      res_ready = !stall || (next_rand() % 32'd4 != 32'd0);
      // handshakes are judged mid cycle, well clear of the rising edge
      #5;
      // with both slots holding a command, a new one only gets in while the result drains
      if (cmd_valid) begin
        check_eq("cmd_ready", 32'(cmd_ready), 32'((sent - got < 2) || res_ready));
      end
      cmd_took = cmd_valid && cmd_ready;
      res_took = res_valid && res_ready;
      if (res_took) begin
        if (exp_q.size() == 0) begin
          abort_run("a result came out with no command outstanding");
        end else begin
          e  = exp_q.pop_front();
          t0 = cyc_q.pop_front();
          check_eq("res.acc", 32'(res.acc), 32'(e.acc));
          check_eq("res.flags", 32'(res.flags), 32'(e.flags));
          check_eq("res.pair_val", 32'(res.pair_val), 32'(e.pair_val));
          if (got < free_cmds) begin
            check_eq("res latency", 32'(cycles - t0), 32'd2);
          end
          got++;
        end
      end
      if (cmd_took) begin
        apply_model(cmd, e);
        exp_q.push_back(e);
        cyc_q.push_back(cycles);
        sent++;
      end
      @(negedge clk);
    end
    // every command gave its one result, so the output must now stay quiet
    cmd_valid = 1'b0;
    res_ready = 1'b1;
    repeat (4) begin
      #5;
      check_eq("res_valid", 32'(res_valid), 32'd0);
      @(negedge clk);
    end
    if (err_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // run length guard
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_lim) begin
      abort_run($sformatf("timeout after %0d cycles with %0d of %0d results seen",
                          cycles, got, num_cmds));
    end
  end

endmodule

// ==== source/alu16.sv ====
`timescale 1ns/1ps

module alu16 import z80_dp_pkg::*; (
  input  op_e               op,
  input  logic [word_w-1:0] pair_word,
  input  logic [byte_w-1:0] imm,
  output logic [word_w-1:0] sum
);

  logic [word_w-1:0] imm_se;

  // the byte is a signed offset, so its top bit fills the high byte
  assign imm_se = {{(word_w - byte_w){imm[byte_w-1]}}, imm};

  // all three forms wrap at 16 bits and leave the flags alone
  always_comb begin
    case (op)
      op_inc16:  sum = pair_word + word_w'(1);
      op_dec16:  sum = pair_word - word_w'(1);
      op_add_se: sum = pair_word + imm_se;
      default:   sum = pair_word;
    endcase
  end

endmodule

// ==== source/alu8.sv ====
`timescale 1ns/1ps

module alu8 import z80_dp_pkg::*; (
  input  op_e               op,
  input  logic [byte_w-1:0] a,
  input  logic [byte_w-1:0] b,
  input  logic [byte_w-1:0] f_in,
  output alu8_out_t         out
);

  logic              is_add;
  logic              is_sub;
  logic              is_step;
  logic [byte_w-1:0] opnd;
  logic [byte_w:0]   sum9;
  logic [byte_w:0]   dif9;
  logic [4:0]        half_sum;
  logic [4:0]        half_dif;

  assign is_step = (op == op_inc_a) || (op == op_dec_a);
  assign is_add  = (op == op_add) || (op == op_inc_a);
  assign is_sub  = (op == op_sub) || (op == op_dec_a);

  // increment and decrement are just add and subtract of one
  assign opnd = is_step ? byte_w'(1) : b;

  // the extra top bit is the carry out, or the borrow for the difference
  assign sum9     = {1'b0, a} + {1'b0, opnd};
  assign dif9     = {1'b0, a} - {1'b0, opnd};
  assign half_sum = {1'b0, a[3:0]} + {1'b0, opnd[3:0]};
  assign half_dif = {1'b0, a[3:0]} - {1'b0, opnd[3:0]};

  always_comb begin
    out.res   = a;
    out.flags = f_in;
    if (is_add || is_sub) begin
      out.res   = is_add ? sum9[byte_w-1:0] : dif9[byte_w-1:0];
      out.flags = '0;
      out.flags[flag_s] = out.res[byte_w-1];
      out.flags[flag_z] = (out.res == '0);
      if (is_add) begin
        out.flags[flag_h]  = half_sum[4];
        // overflow when both inputs share a sign and the result does not
        out.flags[flag_pv] = (a[7] == opnd[7]) && (out.res[7] != a[7]);
        out.flags[flag_n]  = 1'b0;
        out.flags[flag_c]  = sum9[byte_w];
      end else begin
        out.flags[flag_h]  = half_dif[4];
        // for subtract the signs must differ to overflow
        out.flags[flag_pv] = (a[7] != opnd[7]) && (out.res[7] != a[7]);
        out.flags[flag_n]  = 1'b1;
        out.flags[flag_c]  = dif9[byte_w];
      end
      // inc and dec of A keep the old carry
      if (is_step) begin
        out.flags[flag_c] = f_in[flag_c];
      end
    end else if (op == op_scf) begin
      out.flags[flag_c] = 1'b1;
      out.flags[flag_h] = 1'b0;
      out.flags[flag_n] = 1'b0;
    end else if (op == op_ccf) begin
      // the carry before the flip ends up in H
      out.flags[flag_h] = f_in[flag_c];
      out.flags[flag_c] = !f_in[flag_c];
      out.flags[flag_n] = 1'b0;
    end
  end

endmodule

// ==== source/datapath_top.sv ====
`timescale 1ns/1ps

module datapath_top import z80_dp_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    cmd_valid,
  output logic    cmd_ready,
  input  dp_cmd_t cmd,
  output logic    res_valid,
  input  logic    res_ready,
  output dp_res_t res
);

  dp_cmd_t           cmd_q;
  logic              cmd_q_valid;
  logic              res_in_ready;
  logic              fire;
  logic [byte_w-1:0] src_byte;
  logic [word_w-1:0] pair_word;
  logic [byte_w-1:0] acc;
  logic [byte_w-1:0] f;
  logic [byte_w-1:0] operand;
  alu8_out_t         alu8_res;
  logic [word_w-1:0] word_res;
  rf_wr_t            wr;
  dp_res_t           res_next;

  // a held command executes when the result slot can take it
  assign fire = cmd_q_valid && res_in_ready;

  // ----------------------------------------
  // command slot
  // ----------------------------------------
  pipe_reg #(.payload_t(dp_cmd_t)) i_cmd_reg (
    .clk(clk), .rst(rst),
    .in_valid(cmd_valid), .in_ready(cmd_ready), .in_data(cmd),
    .out_valid(cmd_q_valid), .out_ready(res_in_ready), .out_data(cmd_q)
  );

  // operands come straight from the current state, so no forwarding
  regfile i_regfile (
    .clk(clk), .rst(rst), .wr(wr),
    .src_sel(cmd_q.src), .pair_sel(cmd_q.pair),
    .src_byte(src_byte), .pair_word(pair_word)
  );

  // byte and word ALUs run side by side on the same command
  alu8 i_alu8 (
    .op(cmd_q.op), .a(acc), .b(operand), .f_in(f), .out(alu8_res)
  );

  alu16 i_alu16 (
    .op(cmd_q.op), .pair_word(pair_word), .imm(cmd_q.imm), .sum(word_res)
  );

  writeback i_writeback (
    .clk(clk), .rst(rst), .fire(fire), .cmd(cmd_q),
    .src_byte(src_byte), .pair_word(pair_word),
    .alu8_res(alu8_res), .word_res(word_res),
    .wr(wr), .acc(acc), .f(f), .operand(operand), .res(res_next)
  );

  // ----------------------------------------
  // result slot
  // ----------------------------------------
  pipe_reg #(.payload_t(dp_res_t)) i_res_reg (
    .clk(clk), .rst(rst),
    .in_valid(cmd_q_valid), .in_ready(res_in_ready), .in_data(res_next),
    .out_valid(res_valid), .out_ready(res_ready), .out_data(res)
  );

endmodule

// ==== source/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     full;
  payload_t data_q;

  // a new entry can come in while the old one leaves on the same edge
  assign in_ready = !full || out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (in_ready) begin
      full <= in_valid;
    end
  end

  // payload only moves on an input transfer
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      data_q <= in_data;
    end
  end

  assign out_valid = full;
  assign out_data  = data_q;

endmodule

// ==== source/regfile.sv ====
`timescale 1ns/1ps

module regfile import z80_dp_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  rf_wr_t            wr,
  input  reg8_e             src_sel,
  input  pair_e             pair_sel,
  output logic [byte_w-1:0] src_byte,
  output logic [word_w-1:0] pair_word
);

  // main bank and its shadow, index 0 is B and index 5 is L
  logic [byte_w-1:0] bank   [num_regs];
  logic [byte_w-1:0] shadow [num_regs];

  // bank index of the high byte of the read pair and of the written pair
  logic [2:0] rd_hi;
  logic [2:0] wr_hi;

  assign rd_hi = {pair_sel, 1'b0};
  assign wr_hi = {wr.pair_sel, 1'b0};

  // ----------------------------------------
  // reads
  // ----------------------------------------

  // A and IMM are not held here so they read as zero
  // writeback puts the real operand in their place
  assign src_byte = (src_sel <= reg_l) ? bank[src_sel] : '0;

  // the high byte sits at the even index, as B in BC
  assign pair_word = (pair_sel <= pair_hl) ? {bank[rd_hi], bank[rd_hi + 3'd1]} : '0;

  // ----------------------------------------
  // writes
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        bank[i]   <= '0;
        shadow[i] <= '0;
      end
    end else if (wr.exx) begin
      // whole bank trades places with its shadow in one edge
      bank   <= shadow;
      shadow <= bank;
    end else begin
      if (wr.pair_en && wr.pair_sel <= pair_hl) begin
        bank[wr_hi]        <= wr.data[word_w-1:byte_w];
        bank[wr_hi + 3'd1] <= wr.data[byte_w-1:0];
      end
      // only B to L can be written, anything else is ignored
      if (wr.byte_en && wr.byte_sel <= reg_l) begin
        bank[wr.byte_sel] <= wr.data[byte_w-1:0];
      end
    end
  end

endmodule

// ==== source/writeback.sv ====
`timescale 1ns/1ps

module writeback import z80_dp_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              fire,
  input  dp_cmd_t           cmd,
  input  logic [byte_w-1:0] src_byte,
  input  logic [word_w-1:0] pair_word,
  input  alu8_out_t         alu8_res,
  input  logic [word_w-1:0] word_res,
  output rf_wr_t            wr,
  output logic [byte_w-1:0] acc,
  output logic [byte_w-1:0] f,
  output logic [byte_w-1:0] operand,
  output dp_res_t           res
);

  logic [byte_w-1:0] acc_q;
  logic [byte_w-1:0] f_q;
  logic [byte_w-1:0] acc_sh;
  logic [byte_w-1:0] f_sh;
  logic [byte_w-1:0] acc_next;
  logic [byte_w-1:0] f_next;
  logic              pair_written;

  assign acc = acc_q;
  assign f   = f_q;

  // the register file has no A and no immediate, so those are swapped in here
  always_comb begin
    case (cmd.src)
      reg_a:   operand = acc_q;
      reg_imm: operand = cmd.imm;
      default: operand = src_byte;
    endcase
  end

  // ----------------------------------------
  // result routing
  // ----------------------------------------
  always_comb begin
    acc_next = acc_q;
    f_next   = f_q;
    wr       = '0;
    wr.data  = {{(word_w - byte_w){1'b0}}, operand};
    case (cmd.op)
      op_ld: begin
        if (cmd.dst == reg_a) begin
          acc_next = operand;
        end else begin
          // regfile drops a write aimed at IMM
          wr.byte_en  = fire;
          wr.byte_sel = cmd.dst;
        end
      end
      op_add, op_sub, op_inc_a, op_dec_a: begin
        acc_next = alu8_res.res;
        f_next   = alu8_res.flags;
      end
      op_scf, op_ccf: begin
        f_next = alu8_res.flags;
      end
      op_inc16, op_dec16, op_add_se: begin
        wr.pair_en  = fire;
        wr.pair_sel = cmd.pair;
        wr.data     = word_res;
      end
      op_ex_af: begin
        acc_next = acc_sh;
        f_next   = f_sh;
      end
      op_exx: begin
        wr.exx = fire;
      end
      default: begin
      end
    endcase
  end

  // ----------------------------------------
  // A, F and their shadows
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      acc_q  <= '0;
      f_q    <= '0;
      acc_sh <= '0;
      f_sh   <= '0;
    end else if (fire) begin
      acc_q <= acc_next;
      f_q   <= f_next;
      if (cmd.op == op_ex_af) begin
        acc_sh <= acc_q;
        f_sh   <= f_q;
      end
    end
  end

  // word ops report the new pair, everything else the pair as read this cycle
  assign pair_written = (cmd.op == op_inc16) || (cmd.op == op_dec16) ||
                        (cmd.op == op_add_se);

  assign res.acc      = acc_next;
  assign res.flags    = f_next;
  assign res.pair_val = pair_written ? word_res : pair_word;

endmodule

// ==== source/z80_dp_pkg.sv ====
package z80_dp_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  localparam int byte_w   = 8;
  localparam int word_w   = 16;
  // number of byte registers in one bank, B through L
  localparam int num_regs = 6;

  // bit positions inside F, bits 5 and 3 are never set
  localparam int flag_s  = 7;
  localparam int flag_z  = 6;
  localparam int flag_h  = 4;
  localparam int flag_pv = 2;
  localparam int flag_n  = 1;
  localparam int flag_c  = 0;

  // ----------------------------------------
  // encodings
  // ----------------------------------------
  typedef enum logic [3:0] {
    op_nop, op_ld, op_add, op_sub, op_inc_a, op_dec_a, op_inc16,
    op_dec16, op_add_se, op_ex_af, op_exx, op_scf, op_ccf
  } op_e;

  // byte operand select, the first six map straight onto the bank index
  typedef enum logic [2:0] {
    reg_b, reg_c, reg_d, reg_e, reg_h, reg_l, reg_a, reg_imm
  } reg8_e;

  // pair select, times two it gives the bank index of the high byte
  typedef enum logic [1:0] {
    pair_bc, pair_de, pair_hl
  } pair_e;

  // ----------------------------------------
  // structs
  // ----------------------------------------
  typedef struct packed {
    op_e               op;
    reg8_e             dst;
    reg8_e             src;
    pair_e             pair;
    logic [byte_w-1:0] imm;
  } dp_cmd_t;

  typedef struct packed {
    logic [byte_w-1:0] acc;
    logic [byte_w-1:0] flags;
    logic [word_w-1:0] pair_val;
  } dp_res_t;

  typedef struct packed {
    logic [byte_w-1:0] res;
    logic [byte_w-1:0] flags;
  } alu8_out_t;

  // one write request into the B to L bank per execute edge
  typedef struct packed {
    logic              byte_en;
    reg8_e             byte_sel;
    logic              pair_en;
    pair_e             pair_sel;
    logic [word_w-1:0] data;
    logic              exx;
  } rf_wr_t;

endpackage
